// File: flist.f
+incdir+.
rv_pkg.sv
rv_decode_if.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_alu.sv
rv_core.sv
rv_core_tb.sv

// File: rv_alu.sv
`timescale 1ns/1ns

module rv_alu
(
    input  rv_pkg::word_t   i_op1,
    input  rv_pkg::word_t   i_op2,
    input  rv_pkg::alu_op_t i_op,
    output rv_pkg::word_t   o_result,
    output rv_pkg::word_t   o_sum,
    output logic            o_taken
);

    logic          sub;
    rv_pkg::word_t op2_b;
    logic [32:0]   add;
    logic          ovf, lts, ltu, eq, cond;
    logic [4:0]    shamt;
    logic [32:0]   shr;

    // one adder for add, sub and every compare.
    assign sub   = i_op[3] | (i_op[2:1] == 2'b01);
    assign op2_b = sub ? ~i_op2 : i_op2;
    assign add   = {1'b0, i_op1} + {1'b0, op2_b} + {32'd0, sub};
    assign o_sum = add[31:0];

    assign ovf = (i_op1[31] ^ i_op2[31]) & (i_op1[31] ^ add[31]);
    assign lts = add[31] ^ ovf;
    assign ltu = ~add[32];              // borrow out.
    assign eq  = (i_op1 == i_op2);

    assign shamt = i_op2[4:0];
    assign shr   = $signed({i_op[3] & i_op1[31], i_op1}) >>> shamt;

    always_comb
    begin
        case (i_op[2:0])
            3'b000:  o_result = add[31:0];
            3'b001:  o_result = i_op1 << shamt;
            3'b010:  o_result = {31'd0, lts};
            3'b011:  o_result = {31'd0, ltu};
            3'b100:  o_result = i_op1 ^ i_op2;
            3'b101:  o_result = shr[31:0];
            3'b110:  o_result = i_op1 | i_op2;
            default: o_result = i_op1 & i_op2;
        endcase
    end

    always_comb
    begin
        case (i_op[2:1])
            2'b10:   cond = lts;
            2'b11:   cond = ltu;
            default: cond = eq;
        endcase
    end

    assign o_taken = cond ^ i_op[0];    // bne, bge, bgeu invert.

endmodule

// File: rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ########################################################################
// core configuration
// ########################################################################

`define RV_RESET_ADDR   32'h0000_0000

// write-back source codes.
`define RES_ALU         2'd0
`define RES_MEM         2'd1
`define RES_PC4         2'd2

// RV32I base opcodes.
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OP          7'b0110011
`define OPC_OPIMM       7'b0010011

`endif

// File: rv_core.sv
`timescale 1ns/1ns

`include "rv_cfg.svh"

module rv_core
(
    input  logic              i_clk,
    input  logic              i_reset_n,
    output rv_pkg::word_t     o_wb_adr,
    output rv_pkg::word_t     o_wb_dat,
    input  rv_pkg::word_t     i_wb_dat,
    output logic              o_wb_we,
    output logic              o_wb_stb,
    output logic              o_wb_cyc,
    output rv_pkg::byte_sel_t o_wb_sel,
    input  logic              i_wb_ack
);

    rv_pkg::core_state_e state_q, state_d;
    rv_pkg::word_t       fetch_addr, fetch_instr, fetch_pc;
    rv_pkg::word_t       rs1_data, rs2_data, op1, op2;
    rv_pkg::word_t       alu_result, alu_sum;
    logic                alu_taken;
    rv_pkg::word_t       alu3_result, alu3_sum, alu3_target;
    logic                alu3_jump;
    logic                fetch_phase, data_phase, redirect;
    rv_pkg::word_t       mem_rdata, ld_shift, ld_data, wb_data;
    rv_pkg::byte_sel_t   st_sel;
    rv_pkg::word_t       st_data;

    rv_decode_if u_dec_if ();

    // ####################################################################
    // state machine
    // ####################################################################

    always_comb
    begin
        case (state_q)
            rv_pkg::ST_FETCH: state_d = i_wb_ack ? rv_pkg::ST_RS : rv_pkg::ST_FETCH;
            rv_pkg::ST_RS:    state_d = rv_pkg::ST_ALU1;
            rv_pkg::ST_ALU1:  state_d = rv_pkg::ST_ALU2;
            rv_pkg::ST_ALU2:  state_d = rv_pkg::ST_ALU3;
            rv_pkg::ST_ALU3:  state_d = rv_pkg::ST_MEM;
            rv_pkg::ST_MEM:   state_d = rv_pkg::ST_WR;
            default:          state_d = rv_pkg::ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state_q <= rv_pkg::ST_FETCH;
        else
            state_q <= state_d;
    end

    assign fetch_phase = (state_q == rv_pkg::ST_FETCH);
    assign data_phase  = (state_q == rv_pkg::ST_ALU3) &
                         (u_dec_if.store | (u_dec_if.res_src == `RES_MEM));
    assign redirect    = (state_q == rv_pkg::ST_ALU3) & alu3_jump;

    rv_fetch u_fetch
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_ack      (fetch_phase & i_wb_ack),
        .i_instr    (i_wb_dat),
        .i_redirect (redirect),
        .i_target   (alu3_target),
        .o_addr     (fetch_addr),
        .o_instr    (fetch_instr),
        .o_pc       (fetch_pc)
    );

    rv_decode u_decode
    (
        .i_clk   (i_clk),
        .i_instr (fetch_instr),
        .i_pc    (fetch_pc),
        .dec     (u_dec_if.dec)
    );

    rv_regs u_regs
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_rs1     (u_dec_if.rs1),
        .i_rs2     (u_dec_if.rs2),
        .i_rd      (u_dec_if.rd),
        .i_write   ((state_q == rv_pkg::ST_WR) & u_dec_if.reg_write),
        .i_data    (wb_data),
        .o_data1   (rs1_data),
        .o_data2   (rs2_data)
    );

    // ####################################################################
    // execute
    // ####################################################################

    assign op1 = u_dec_if.op1_pc ? u_dec_if.pc : rs1_data;
    assign op2 = u_dec_if.op2_imm ? u_dec_if.imm : rs2_data;

    rv_alu u_alu
    (
        .i_op1    (op1),
        .i_op2    (op2),
        .i_op     (u_dec_if.alu_op),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_taken  (alu_taken)
    );

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            alu3_jump <= 1'b0;
        else if (state_q == rv_pkg::ST_ALU2)
            alu3_jump <= u_dec_if.jal | u_dec_if.jalr | (u_dec_if.branch & alu_taken);
    end

    always_ff @(posedge i_clk)
    begin
        if (state_q == rv_pkg::ST_ALU2)
        begin
            alu3_result <= alu_result;
            alu3_sum    <= alu_sum;
            alu3_target <= u_dec_if.jalr ? {alu_sum[31:1], 1'b0}
                                         : u_dec_if.pc + u_dec_if.imm;
        end
        if (state_q == rv_pkg::ST_MEM)
            mem_rdata <= i_wb_dat;      // load data, one cycle after strobe.
    end

    // ####################################################################
    // memory lanes and write-back
    // ####################################################################

    always_comb
    begin
        case (u_dec_if.funct3[1:0])
            2'b00:
            begin
                st_sel  = 4'b0001 << alu3_sum[1:0];
                st_data = {4{rs2_data[7:0]}};
            end
            2'b01:
            begin
                st_sel  = alu3_sum[1] ? 4'b1100 : 4'b0011;
                st_data = {2{rs2_data[15:0]}};
            end
            default:
            begin
                st_sel  = 4'b1111;
                st_data = rs2_data;
            end
        endcase
    end

    assign ld_shift = mem_rdata >> {alu3_sum[1:0], 3'b000};

    always_comb
    begin
        case (u_dec_if.funct3)
            3'b000:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
            3'b001:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
            3'b100:  ld_data = {24'd0, ld_shift[7:0]};
            3'b101:  ld_data = {16'd0, ld_shift[15:0]};
            default: ld_data = mem_rdata;
        endcase
    end

    always_comb
    begin
        case (u_dec_if.res_src)
            `RES_MEM: wb_data = ld_data;
            `RES_PC4: wb_data = u_dec_if.pc + 32'd4;  // link address.
            default:  wb_data = alu3_result;
        endcase
    end

    // bus is shared, fetch unless a data access is on.
    assign o_wb_cyc = fetch_phase | data_phase;
    assign o_wb_stb = fetch_phase | data_phase;
    assign o_wb_we  = data_phase & u_dec_if.store;
    assign o_wb_adr = data_phase ? {alu3_sum[31:2], 2'b00} : fetch_addr;
    assign o_wb_sel = data_phase ? st_sel : 4'b1111;
    assign o_wb_dat = st_data;

endmodule

// File: rv_core_tb.sv
`timescale 1ns/1ns

`include "rv_cfg.svh"

module rv_core_tb;

    localparam int            CLK_PERIOD = 10;
    localparam int            MEM_WORDS  = 2048;
    localparam int            MAX_INSTR  = 256;
    localparam int            WORST_CPI  = 12;      // fetch with 3 waits, ack, six states.
    localparam int            RUN_LIMIT  = MAX_INSTR * WORST_CPI;
    localparam int            RUNS       = 6;
    localparam rv_pkg::word_t DATA_BASE  = 32'h0000_1000;
    localparam rv_pkg::word_t SCRATCH    = 32'h0000_1200;
    localparam rv_pkg::word_t DONE_ADR   = 32'h0000_17FC;

    logic              clk        = 1'b0;
    logic              reset_n    = 1'b0;
    rv_pkg::word_t     wb_adr;
    rv_pkg::word_t     wb_dat_out;
    rv_pkg::word_t     wb_dat_in  = '0;
    logic              wb_we;
    logic              wb_stb;
    logic              wb_cyc;
    rv_pkg::byte_sel_t wb_sel;
    logic              wb_ack     = 1'b0;

    integer            seed       = 32'h91fd84cb;
    int                errors     = 0;
    int                checks     = 0;
    logic              random_acks = 1'b0;
    logic              done       = 1'b0;
    int                wait_cnt   = 0;
    rv_pkg::word_t     mem [0:MEM_WORDS-1];

    // program image and what it is expected to do on the bus.
    rv_pkg::word_t     prog[$];
    rv_pkg::word_t     exp_fetch[$];
    rv_pkg::word_t     exp_adr[$];
    rv_pkg::word_t     exp_dat[$];
    rv_pkg::byte_sel_t exp_sel[$];
    rv_pkg::word_t     obs_fetch[$];
    rv_pkg::word_t     obs_adr[$];
    rv_pkg::word_t     obs_dat[$];
    rv_pkg::byte_sel_t obs_sel[$];
    int                res_off;

    rv_core u_dut
    (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .o_wb_adr  (wb_adr),
        .o_wb_dat  (wb_dat_out),
        .i_wb_dat  (wb_dat_in),
        .o_wb_we   (wb_we),
        .o_wb_stb  (wb_stb),
        .o_wb_cyc  (wb_cyc),
        .o_wb_sel  (wb_sel),
        .i_wb_ack  (wb_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ########################################################################
    // bus model
    // ########################################################################

    always @(posedge clk)
    begin : bus_model
        rv_pkg::word_t merged;
        int            idx;
        int            k;
        idx    = wb_adr[12:2];
        merged = mem[idx];
        for (k = 0; k < 4; k++)
            if (wb_sel[k])
                merged[k*8 +: 8] = wb_dat_out[k*8 +: 8];
        if (reset_n && wb_stb)
            check_bit("o_wb_cyc", wb_cyc, 1'b1);
        if (!reset_n)
        begin
            wb_ack   <= 1'b0;
            wait_cnt <= 0;
            done     <= 1'b0;
        end
        else if (wb_stb && wb_ack)
        begin
            wb_ack <= 1'b0;             // fetch completes at this edge.
            obs_fetch.push_back(wb_adr);
            check_bit("o_wb_we (fetch)", wb_we, 1'b0);
        end
        else if (wb_stb)
        begin
            if (wb_we && wb_adr == DONE_ADR)
                done <= 1'b1;
            else if (wb_we)
            begin
                mem[idx] <= merged;
                obs_adr.push_back(wb_adr);
                obs_dat.push_back(wb_dat_out);
                obs_sel.push_back(wb_sel);
            end
            else
                wb_dat_in <= mem[idx];  // valid one cycle later.
            if (wait_cnt > 0)
                wait_cnt <= wait_cnt - 1;
            else
            begin
                wb_ack   <= 1'b1;
                wait_cnt <= random_acks ? ($unsigned($random(seed)) % 4) : 0;
            end
        end
        else
            wb_ack <= 1'b0;
    end

    // ########################################################################
    // encoders and reference model
    // ########################################################################

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
        input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
        input logic [2:0] f3, input rv_pkg::reg_idx_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
        input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input rv_pkg::reg_idx_t rs2,
        input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
        input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic rv_pkg::word_t alu_ref(input logic alt, input logic [2:0] f3,
        input rv_pkg::word_t a, input rv_pkg::word_t b);
        rv_pkg::word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv_pkg::word_t a,
        input rv_pkg::word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ########################################################################
    // program building
    // ########################################################################

    function automatic rv_pkg::word_t here();
        return `RV_RESET_ADDR + 32'(4 * prog.size());
    endfunction

    task automatic emit(input rv_pkg::word_t w);
        exp_fetch.push_back(here());
        prog.push_back(w);
    endtask

    task automatic emit_skipped(input rv_pkg::word_t w);
        prog.push_back(w);              // never fetched.
    endtask

    task automatic expect_store(input rv_pkg::word_t adr, input rv_pkg::word_t dat,
        input rv_pkg::byte_sel_t sel);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
        exp_sel.push_back(sel);
    endtask

    task automatic load_const(input rv_pkg::reg_idx_t rd, input rv_pkg::word_t v);
        rv_pkg::word_t up;
        up = v + 32'h800;               // addi sign-extends its immediate.
        emit(enc_u(up[31:12], rd, `OPC_LUI));
        emit(enc_i(v[11:0], rd, 3'd0, rd, `OPC_OPIMM));
    endtask

    task automatic store_result(input rv_pkg::reg_idx_t rs, input rv_pkg::word_t value);
        emit(enc_s(12'(res_off), rs, 5'd31, 3'b010));
        expect_store(DATA_BASE + 32'(res_off), value, 4'b1111);
        res_off += 4;
    endtask

    task automatic new_program();
        prog.delete();
        exp_fetch.delete();
        exp_adr.delete();
        exp_dat.delete();
        exp_sel.delete();
        res_off = 0;
        emit(enc_u(20'h00001, 5'd31, `OPC_LUI));    // x31 is the result base.
    endtask

    task automatic end_program();
        emit(enc_s(12'h7FC, 5'd0, 5'd31, 3'b010));  // end marker store.
        emit_skipped(enc_j(21'd0, 5'd0));
    endtask

    // ########################################################################
    // checks and program run
    // ########################################################################

    task automatic check_word(input string name, input rv_pkg::word_t got,
        input rv_pkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input rv_pkg::byte_sel_t got,
        input rv_pkg::byte_sel_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic run_program(input logic slow);
        int cycles;
        int i;
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (5) @(posedge clk);
        for (i = 0; i < MEM_WORDS; i++)
            mem[i] = ((32'(i) << 2) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
        for (i = 0; i < prog.size(); i++)
            mem[`RV_RESET_ADDR / 4 + i] = prog[i];
        obs_fetch.delete();
        obs_adr.delete();
        obs_dat.delete();
        obs_sel.delete();
        random_acks = slow;
        reset_n <= 1'b1;
        cycles = 0;
        while (!done && cycles < RUN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
        begin
            errors++;
            $display("program did not reach its end marker store");
        end
        if (obs_fetch.size() != exp_fetch.size() || obs_adr.size() != exp_adr.size())
        begin
            errors++;
            $display("saw %0d fetches and %0d stores, expected %0d and %0d",
                     obs_fetch.size(), obs_adr.size(), exp_fetch.size(), exp_adr.size());
        end
        for (i = 0; i < obs_fetch.size() && i < exp_fetch.size(); i++)
            check_word("o_wb_adr (fetch)", obs_fetch[i], exp_fetch[i]);
        for (i = 0; i < obs_adr.size() && i < exp_adr.size(); i++)
        begin
            check_word("o_wb_adr (store)", obs_adr[i], exp_adr[i]);
            check_word("o_wb_dat", obs_dat[i], exp_dat[i]);
            check_sel("o_wb_sel", obs_sel[i], exp_sel[i]);
        end
    endtask

    // ########################################################################
    // directed tests
    // ########################################################################

    task automatic test_alu();
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        logic [11:0]   imm;
        int            p;
        int            f3;
        new_program();
        for (p = 0; p < 3; p++)
        begin
            a = (p == 0) ? 32'h8000_0000 : $random(seed);
            b = (p == 0) ? 32'h7FFF_FFFF : $random(seed);
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (f3 = 0; f3 < 8; f3++)
            begin
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), 5'd3));
                store_result(5'd3, alu_ref(1'b0, 3'(f3), a, b));
            end
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));     // sub.
            store_result(5'd3, alu_ref(1'b1, 3'd0, a, b));
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));     // sra.
            store_result(5'd3, alu_ref(1'b1, 3'd5, a, b));
            for (f3 = 0; f3 < 8; f3++)
            begin
                imm = 12'($random(seed));
                if (f3 == 1 || f3 == 5)
                    imm = {7'h00, imm[4:0]};
                emit(enc_i(imm, 5'd1, 3'(f3), 5'd3, `OPC_OPIMM));
                store_result(5'd3, alu_ref(1'b0, 3'(f3), a, {{20{imm[11]}}, imm}));
                if (f3 == 5)
                begin
                    emit(enc_i({7'h20, imm[4:0]}, 5'd1, 3'd5, 5'd3, `OPC_OPIMM));
                    store_result(5'd3, alu_ref(1'b1, 3'd5, a, {27'd0, imm[4:0]}));
                end
            end
        end
        // writes to x0 must vanish.
        emit(enc_i(12'h123, 5'd1, 3'd0, 5'd0, `OPC_OPIMM));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        emit(enc_u(20'hABCDE, 5'd0, `OPC_LUI));
        store_result(5'd0, 32'd0);
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd4));
        store_result(5'd4, 32'd0);
        end_program();
        run_program(1'b0);
        run_program(1'b1);
    endtask

    task automatic test_load_store();
        logic [7:0]    image [0:11];
        rv_pkg::word_t v;
        int            off;
        new_program();
        load_const(5'd30, SCRATCH);
        for (off = 0; off < 4; off++)
        begin
            v    = $random(seed);
            v[7] = off[0];              // odd lanes hold negative bytes.
            load_const(5'd1, v);
            emit(enc_s(12'(off), 5'd1, 5'd30, 3'b000));
            expect_store(SCRATCH, {4{v[7:0]}}, 4'b0001 << off);
            image[off] = v[7:0];
        end
        for (off = 4; off < 8; off += 2)
        begin
            v     = $random(seed);
            v[15] = (off == 4);
            load_const(5'd1, v);
            emit(enc_s(12'(off), 5'd1, 5'd30, 3'b001));
            expect_store(SCRATCH + 4, {2{v[15:0]}}, (off == 6) ? 4'b1100 : 4'b0011);
            image[off]     = v[7:0];
            image[off + 1] = v[15:8];
        end
        v = $random(seed);
        load_const(5'd1, v);
        emit(enc_s(12'd8, 5'd1, 5'd30, 3'b010));
        expect_store(SCRATCH + 8, v, 4'b1111);
        {image[11], image[10], image[9], image[8]} = v;
        for (off = 0; off < 4; off++)
        begin
            emit(enc_i(12'(off), 5'd30, 3'b000, 5'd2, `OPC_LOAD));
            store_result(5'd2, {{24{image[off][7]}}, image[off]});
            emit(enc_i(12'(off), 5'd30, 3'b100, 5'd2, `OPC_LOAD));
            store_result(5'd2, {24'd0, image[off]});
        end
        for (off = 0; off < 8; off += 2)
        begin
            emit(enc_i(12'(off), 5'd30, 3'b001, 5'd2, `OPC_LOAD));
            store_result(5'd2, {{16{image[off + 1][7]}}, image[off + 1], image[off]});
            emit(enc_i(12'(off), 5'd30, 3'b101, 5'd2, `OPC_LOAD));
            store_result(5'd2, {16'd0, image[off + 1], image[off]});
        end
        for (off = 0; off < 12; off += 4)
        begin
            emit(enc_i(12'(off), 5'd30, 3'b010, 5'd2, `OPC_LOAD));
            store_result(5'd2, {image[off + 3], image[off + 2], image[off + 1], image[off]});
        end
        end_program();
        run_program(1'b0);
        run_program(1'b1);
    endtask

    task automatic test_control();
        rv_pkg::word_t    v1;
        rv_pkg::word_t    v2;
        rv_pkg::word_t    base;
        rv_pkg::reg_idx_t ra;
        rv_pkg::reg_idx_t rb;
        logic             taken;
        int               f3;
        int               p;
        new_program();
        v1 = 32'hFFFF_FFFB;
        v2 = 32'd3;
        load_const(5'd1, v1);
        load_const(5'd2, v2);
        for (f3 = 0; f3 < 8; f3++)
        begin
            if (f3 == 2 || f3 == 3)
                continue;
            for (p = 0; p < 3; p++)
            begin
                ra    = (p == 2) ? 5'd2 : 5'd1;
                rb    = (p == 1) ? 5'd2 : 5'd1;
                taken = branch_ref(3'(f3), (ra == 5'd1) ? v1 : v2, (rb == 5'd1) ? v1 : v2);
                emit(enc_i(12'd0, 5'd0, 3'd0, 5'd5, `OPC_OPIMM));
                emit(enc_b(13'd8, rb, ra, 3'(f3)));
                if (taken)
                    emit_skipped(enc_i(12'd1, 5'd0, 3'd0, 5'd5, `OPC_OPIMM));
                else
                    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd5, `OPC_OPIMM));
                store_result(5'd5, taken ? 32'd0 : 32'd1);
            end
        end
        base = here();
        emit(enc_j(21'd12, 5'd6));
        emit_skipped(enc_i(12'd1, 5'd0, 3'd0, 5'd7, `OPC_OPIMM));
        emit_skipped(enc_i(12'd2, 5'd0, 3'd0, 5'd7, `OPC_OPIMM));
        store_result(5'd6, base + 4);
        base = here();
        emit(enc_u(20'd0, 5'd8, `OPC_AUIPC));
        emit(enc_i(12'd17, 5'd8, 3'd0, 5'd9, `OPC_JALR));   // bit 0 of target cleared.
        emit_skipped(enc_i(12'd1, 5'd0, 3'd0, 5'd7, `OPC_OPIMM));
        emit_skipped(enc_i(12'd2, 5'd0, 3'd0, 5'd7, `OPC_OPIMM));
        store_result(5'd9, base + 8);
        store_result(5'd8, base);
        end_program();
        run_program(1'b0);
        run_program(1'b1);
    endtask

    initial
    begin : watchdog
        #(2 * RUNS * (RUN_LIMIT + 10) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        test_alu();
        test_load_store();
        test_control();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: rv_decode.sv
`timescale 1ns/1ns

`include "rv_cfg.svh"

module rv_decode
(
    input  logic          i_clk,
    input  rv_pkg::word_t i_instr,
    input  rv_pkg::word_t i_pc,
    rv_decode_if.dec      dec
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    rv_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::word_t    imm_n;
    rv_pkg::reg_idx_t rs1_n;
    rv_pkg::alu_op_t  alu_op_n;
    rv_pkg::res_src_t res_src_n;
    logic             op1_pc_n, op2_imm_n, reg_write_n;
    logic             store_n, jal_n, jalr_n, branch_n;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];

    // ####################################################################
    // immediates
    // ####################################################################

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'd0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // ####################################################################
    // control
    // ####################################################################

    always_comb
    begin
        imm_n       = imm_i;
        rs1_n       = i_instr[19:15];
        alu_op_n    = 4'b0000;          // add.
        res_src_n   = `RES_ALU;
        op1_pc_n    = 1'b0;
        op2_imm_n   = 1'b0;
        reg_write_n = 1'b0;
        store_n     = 1'b0;
        jal_n       = 1'b0;
        jalr_n      = 1'b0;
        branch_n    = 1'b0;
        case (opcode)
            `OPC_LUI:
            begin
                imm_n       = imm_u;
                rs1_n       = 5'd0;     // x0 + imm.
                op2_imm_n   = 1'b1;
                reg_write_n = 1'b1;
            end
            `OPC_AUIPC:
            begin
                imm_n       = imm_u;
                op1_pc_n    = 1'b1;
                op2_imm_n   = 1'b1;
                reg_write_n = 1'b1;
            end
            `OPC_JAL:
            begin
                imm_n       = imm_j;
                op1_pc_n    = 1'b1;
                op2_imm_n   = 1'b1;
                res_src_n   = `RES_PC4;
                reg_write_n = 1'b1;
                jal_n       = 1'b1;
            end
            `OPC_JALR:
            begin
                op2_imm_n   = 1'b1;
                res_src_n   = `RES_PC4;
                reg_write_n = 1'b1;
                jalr_n      = 1'b1;
            end
            `OPC_BRANCH:
            begin
                imm_n    = imm_b;
                alu_op_n = {1'b1, funct3};  // subtract, compare by funct3.
                branch_n = 1'b1;
            end
            `OPC_LOAD:
            begin
                op2_imm_n   = 1'b1;
                res_src_n   = `RES_MEM;
                reg_write_n = 1'b1;
            end
            `OPC_STORE:
            begin
                imm_n     = imm_s;
                op2_imm_n = 1'b1;
                store_n   = 1'b1;
            end
            `OPC_OP:
            begin
                alu_op_n    = {i_instr[30], funct3};
                reg_write_n = 1'b1;
            end
            `OPC_OPIMM:
            begin
                // only srai carries bit 30 as an op bit.
                alu_op_n    = {i_instr[30] & (funct3 == 3'b101), funct3};
                op2_imm_n   = 1'b1;
                reg_write_n = 1'b1;
            end
            default:
            begin
                reg_write_n = 1'b0;     // fence, system: no-op.
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        dec.rs1       <= rs1_n;
        dec.rs2       <= i_instr[24:20];
        dec.rd        <= i_instr[11:7];
        dec.imm       <= imm_n;
        dec.pc        <= i_pc;
        dec.alu_op    <= alu_op_n;
        dec.op1_pc    <= op1_pc_n;
        dec.op2_imm   <= op2_imm_n;
        dec.res_src   <= res_src_n;
        dec.reg_write <= reg_write_n;
        dec.store     <= store_n;
        dec.jal       <= jal_n;
        dec.jalr      <= jalr_n;
        dec.branch    <= branch_n;
        dec.funct3    <= funct3;
    end

endmodule

// File: rv_decode_if.sv
`timescale 1ns/1ns

interface rv_decode_if;

    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    pc;
    rv_pkg::alu_op_t  alu_op;
    logic             op1_pc;     // op1 is pc, else rs1.
    logic             op2_imm;    // op2 is imm, else rs2.
    rv_pkg::res_src_t res_src;
    logic             reg_write;
    logic             store;
    logic             jal;
    logic             jalr;
    logic             branch;
    logic [2:0]       funct3;

    modport dec
    (
        output rs1, rs2, rd, imm, pc, alu_op, op1_pc, op2_imm,
        output res_src, reg_write, store, jal, jalr, branch, funct3
    );

    modport core
    (
        input  rs1, rs2, rd, imm, pc, alu_op, op1_pc, op2_imm,
        input  res_src, reg_write, store, jal, jalr, branch, funct3
    );

endinterface

// File: rv_fetch.sv
`timescale 1ns/1ns

`include "rv_cfg.svh"

module rv_fetch
(
    input  logic          i_clk,
    input  logic          i_reset_n,
    input  logic          i_ack,
    input  rv_pkg::word_t i_instr,
    input  logic          i_redirect,
    input  rv_pkg::word_t i_target,
    output rv_pkg::word_t o_addr,
    output rv_pkg::word_t o_instr,
    output rv_pkg::word_t o_pc
);

    rv_pkg::word_t pc_q;

    assign o_addr = pc_q;

    // redirect comes at the end of alu3, never together with an ack.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc_q <= `RV_RESET_ADDR;
        else if (i_redirect)
            pc_q <= i_target;
        else if (i_ack)
            pc_q <= pc_q + 32'd4;       // sequential step.
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ack)
        begin
            o_instr <= i_instr;
            o_pc    <= pc_q;            // address the word came from.
        end
    end

endmodule

// File: rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;        // data, address or pc.
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;      // {sub/sra, funct3}.
    typedef logic [1:0]  res_src_t;
    typedef logic [3:0]  byte_sel_t;

    // one instruction walks through all seven states.
    typedef enum logic [2:0]
    {
        ST_FETCH = 3'd0,
        ST_RS    = 3'd1,
        ST_ALU1  = 3'd2,
        ST_ALU2  = 3'd3,
        ST_ALU3  = 3'd4,
        ST_MEM   = 3'd5,
        ST_WR    = 3'd6
    } core_state_e;

endpackage

// File: rv_regs.sv
`timescale 1ns/1ns

module rv_regs
(
    input  logic             i_clk,
    input  logic             i_reset_n,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  logic             i_write,
    input  rv_pkg::word_t    i_data,
    output rv_pkg::word_t    o_data1,
    output rv_pkg::word_t    o_data2
);

    rv_pkg::word_t regs [1:31];         // x0 has no storage.

    always_ff @(posedge i_clk)
    begin
        if (i_write && (i_rd != 5'd0))
            regs[i_rd] <= i_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_data1 <= '0;
            o_data2 <= '0;
        end
        else
        begin
            o_data1 <= (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
            o_data2 <= (i_rs2 == 5'd0) ? '0 : regs[i_rs2];
        end
    end

endmodule
